// File: rtl/mul_pkg.sv
/* booth wallace multiplier definitions */

`default_nettype none

package mul_pkg;

    // --------------------------------------------------
    // operand and product widths
    // --------------------------------------------------
    localparam int OPERAND_W = 53;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // radix-4 digits over the sign-extended 54-bit multiplier
    localparam int NUM_PP = OPERAND_W / 2 + 1;

    // selected partial product, holds -2m .. +2m
    localparam int PP_W = OPERAND_W + 2;

    // partial products plus the negate/correction row
    localparam int NUM_ROWS = NUM_PP + 1;

    // --------------------------------------------------
    // reduction tree shape
    // --------------------------------------------------
    localparam int LVL0_ROWS = 14;
    localparam int LVL1_ROWS = 8;
    localparam int LVL2_ROWS = 4;
    localparam int LVL3_ROWS = 2;

    // four tree levels plus the final adder
    localparam int PIPE_DEPTH = 5;

    // final adder, 4-bit groups inside 16-bit blocks
    localparam int CLA_BLOCKS = (PRODUCT_W + 15) / 16;
    localparam int CLA_GROUPS = 4 * CLA_BLOCKS;
    localparam int CLA_W = 16 * CLA_BLOCKS;

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [PRODUCT_W-1:0] product_t;

    // one carry-save row, bit k has weight 2^k
    typedef logic [PRODUCT_W-1:0] row_t;

endpackage

`default_nettype wire

// File: rtl/booth_pp_gen.sv
/* radix-4 booth partial products */

`timescale 1ns/1ps
`default_nettype none

module booth_pp_gen (
    input logic signed_mode,
    input mul_pkg::operand_t multiplicand,
    input mul_pkg::operand_t multiplier,
    output mul_pkg::row_t rows [mul_pkg::NUM_ROWS]
);

    // 54-bit multiplicand, sign or zero extended
    logic [mul_pkg::OPERAND_W:0] m_ext;

    // 54-bit multiplier with the implicit y[-1] = 0 below it
    logic [mul_pkg::OPERAND_W+1:0] y_ext;

    // +m and +2m, both PP_W wide
    logic [mul_pkg::PP_W-1:0] m_one;
    logic [mul_pkg::PP_W-1:0] m_two;

    logic [mul_pkg::NUM_PP-1:0] neg;
    mul_pkg::row_t corr_row;

    assign m_ext = {signed_mode & multiplicand[mul_pkg::OPERAND_W-1], multiplicand};
    assign y_ext = {signed_mode & multiplier[mul_pkg::OPERAND_W-1], multiplier, 1'b0};

    assign m_one = {m_ext[mul_pkg::OPERAND_W], m_ext};
    assign m_two = {m_ext, 1'b0};

    // --------------------------------------------------
    // digit recoding and selection
    // --------------------------------------------------
    genvar i;
    generate
        for (i = 0; i < mul_pkg::NUM_PP; i++)
        begin : g_pp
            logic [2:0] win;
            logic sel_one;
            logic sel_two;
            logic [mul_pkg::PP_W-1:0] sel;
            logic [mul_pkg::PP_W-1:0] pp;
            logic sgn;
            logic [mul_pkg::PP_W+1:0] ext;

            // overlapping window y[2i+1], y[2i], y[2i-1]
            assign win = y_ext[2*i+2 : 2*i];

            assign sel_one = win[1] ^ win[0];
            assign sel_two = (win[2] & ~win[1] & ~win[0]) | (~win[2] & win[1] & win[0]);

            // 111 is a zero digit, so no negate there
            assign neg[i] = win[2] & ~(win[1] & win[0]);

            assign sel = sel_one ? m_one : (sel_two ? m_two : '0);

            // ones' complement here, the +1 goes into the correction row
            assign pp = sel ^ {mul_pkg::PP_W{neg[i]}};
            assign sgn = pp[mul_pkg::PP_W-1];

            // sign compression prefix
            // row 0 takes ~s,s,s and the others 1,~s
            assign ext = (i == 0) ?
                {~sgn, sgn, sgn, pp[mul_pkg::PP_W-2:0]} :
                {1'b0, 1'b1, ~sgn, pp[mul_pkg::PP_W-2:0]};

            // placed at column 2i, anything above column 105 falls off
            assign rows[i] = mul_pkg::row_t'(ext) << (2 * i);
        end
    endgenerate

    // --------------------------------------------------
    // correction row
    // --------------------------------------------------
    // the leading ones of rows 1..26 together with the extra
    // weight of the row 0 prefix add up to 2^108, so the
    // compression constant is zero modulo 2^106 and this row
    // only carries the negate bits
    always_comb
    begin
        corr_row = '0;
        for (int k = 0; k < mul_pkg::NUM_PP; k++)
        begin
            corr_row[2*k] = neg[k];
        end
    end

    assign rows[mul_pkg::NUM_ROWS-1] = corr_row;

endmodule

`default_nettype wire

// File: rtl/csa_level.sv
/* 4:2 compressor tree level */

`timescale 1ns/1ps
`default_nettype none

module csa_level #(
    parameter int IN_ROWS = 4,
    parameter int OUT_ROWS = 2
) (
    input logic clk,
    input logic reset,
    input logic run,
    input mul_pkg::row_t rows_in [IN_ROWS],
    output mul_pkg::row_t rows_out [OUT_ROWS]
);

    // combinational result of this level
    mul_pkg::row_t rows_next [OUT_ROWS];

    genvar gi;
    genvar pi;

    // --------------------------------------------------
    // compressor arrays
    // --------------------------------------------------
    // every group of four rows goes through one row of 4:2
    // cells, which gives one sum row and one carry row
    generate
        for (gi = 0; gi < IN_ROWS / 4; gi++)
        begin : g_cmp
            mul_pkg::row_t x1;
            mul_pkg::row_t x2;
            mul_pkg::row_t x3;
            mul_pkg::row_t x4;
            mul_pkg::row_t fa1_sum;
            mul_pkg::row_t hor;
            mul_pkg::row_t hor_in;
            mul_pkg::row_t fa2_carry;

            assign x1 = rows_in[4*gi];
            assign x2 = rows_in[4*gi+1];
            assign x3 = rows_in[4*gi+2];
            assign x4 = rows_in[4*gi+3];

            // first full adder of each column
            assign fa1_sum = x1 ^ x2 ^ x3;
            assign hor = (x1 & x2) | (x1 & x3) | (x2 & x3);

            // horizontal carry into the next column
            // it does not depend on the incoming one, so no ripple
            assign hor_in = {hor[mul_pkg::PRODUCT_W-2:0], 1'b0};

            // second full adder
            assign rows_next[2*gi] = fa1_sum ^ x4 ^ hor_in;
            assign fa2_carry = (fa1_sum & x4) | (fa1_sum & hor_in) | (x4 & hor_in);

            // carry row moves up one column, top bit is dropped
            assign rows_next[2*gi+1] = {fa2_carry[mul_pkg::PRODUCT_W-2:0], 1'b0};
        end

        // leftover rows skip this level
        for (pi = 0; pi < IN_ROWS % 4; pi++)
        begin : g_pass
            assign rows_next[2*(IN_ROWS/4) + pi] = rows_in[4*(IN_ROWS/4) + pi];
        end
    endgenerate

    // --------------------------------------------------
    // level register
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rows_out <= '{default: '0};
        end
        else if (run)
        begin
            rows_out <= rows_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/final_cla_stage.sv
/* final carry-lookahead adder */

`timescale 1ns/1ps
`default_nettype none

module final_cla_stage (
    input logic clk,
    input logic reset,
    input logic run,
    input mul_pkg::row_t sum_row,
    input mul_pkg::row_t carry_row,
    output mul_pkg::product_t product
);

    // operands padded up to a whole number of 16-bit blocks
    logic [mul_pkg::CLA_W-1:0] op_a;
    logic [mul_pkg::CLA_W-1:0] op_b;
    logic [mul_pkg::CLA_W-1:0] gen;
    logic [mul_pkg::CLA_W-1:0] prop;
    logic [mul_pkg::CLA_W-1:0] carry;

    logic [mul_pkg::CLA_GROUPS-1:0] grp_g;
    logic [mul_pkg::CLA_GROUPS-1:0] grp_p;
    logic [mul_pkg::CLA_GROUPS-1:0] grp_c;

    logic [mul_pkg::CLA_BLOCKS-1:0] blk_g;
    logic [mul_pkg::CLA_BLOCKS-1:0] blk_p;
    logic [mul_pkg::CLA_BLOCKS-1:0] blk_c;

    mul_pkg::product_t sum_next;

    // carry into each of four positions
    function automatic logic [3:0] carry4(
        input logic [3:0] g,
        input logic [3:0] p,
        input logic cin
    );
        carry4[0] = cin;
        carry4[1] = g[0] | (p[0] & cin);
        carry4[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
        carry4[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) |
                    (p[2] & p[1] & p[0] & cin);
    endfunction

    // generate term of four positions
    function automatic logic gen4(
        input logic [3:0] g,
        input logic [3:0] p
    );
        return g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);
    endfunction

    assign op_a = {{(mul_pkg::CLA_W - mul_pkg::PRODUCT_W){1'b0}}, sum_row};
    assign op_b = {{(mul_pkg::CLA_W - mul_pkg::PRODUCT_W){1'b0}}, carry_row};

    assign gen = op_a & op_b;
    assign prop = op_a ^ op_b;

    // --------------------------------------------------
    // two-level lookahead
    // --------------------------------------------------
    always_comb
    begin
        for (int k = 0; k < mul_pkg::CLA_GROUPS; k++)
        begin
            grp_g[k] = gen4(gen[4*k +: 4], prop[4*k +: 4]);
            grp_p[k] = &prop[4*k +: 4];
        end

        // groups of four form a block, blocks pass their carry on
        blk_c[0] = 1'b0;
        for (int j = 0; j < mul_pkg::CLA_BLOCKS; j++)
        begin
            blk_g[j] = gen4(grp_g[4*j +: 4], grp_p[4*j +: 4]);
            blk_p[j] = &grp_p[4*j +: 4];
            if (j + 1 < mul_pkg::CLA_BLOCKS)
            begin
                blk_c[j+1] = blk_g[j] | (blk_p[j] & blk_c[j]);
            end
            grp_c[4*j +: 4] = carry4(grp_g[4*j +: 4], grp_p[4*j +: 4], blk_c[j]);
        end

        for (int k = 0; k < mul_pkg::CLA_GROUPS; k++)
        begin
            carry[4*k +: 4] = carry4(gen[4*k +: 4], prop[4*k +: 4], grp_c[k]);
        end
    end

    // carry out of column 105 is not needed
    assign sum_next = prop[mul_pkg::PRODUCT_W-1:0] ^ carry[mul_pkg::PRODUCT_W-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            product <= '0;
        end
        else if (run)
        begin
            product <= sum_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/booth_wallace_mul.sv
/* pipelined booth wallace multiplier */

`timescale 1ns/1ps
`default_nettype none

module booth_wallace_mul (
    input logic clk,
    input logic reset,
    input logic run,
    input logic signed_mode,
    input mul_pkg::operand_t multiplicand,
    input mul_pkg::operand_t multiplier,
    output mul_pkg::product_t product
);

    // --------------------------------------------------
    // row arrays between stages
    // --------------------------------------------------
    mul_pkg::row_t pp_rows [mul_pkg::NUM_ROWS];
    mul_pkg::row_t lvl0_rows [mul_pkg::LVL0_ROWS];
    mul_pkg::row_t lvl1_rows [mul_pkg::LVL1_ROWS];
    mul_pkg::row_t lvl2_rows [mul_pkg::LVL2_ROWS];
    mul_pkg::row_t lvl3_rows [mul_pkg::LVL3_ROWS];

    // partial products, combinational
    booth_pp_gen u_pp_gen (
        .signed_mode (signed_mode),
        .multiplicand(multiplicand),
        .multiplier  (multiplier),
        .rows        (pp_rows)
    );

    // 28 -> 14, operands are captured here
    csa_level #(
        .IN_ROWS (mul_pkg::NUM_ROWS),
        .OUT_ROWS(mul_pkg::LVL0_ROWS)
    ) u_lvl0 (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .rows_in (pp_rows),
        .rows_out(lvl0_rows)
    );

    // 14 -> 8, two rows pass through
    csa_level #(
        .IN_ROWS (mul_pkg::LVL0_ROWS),
        .OUT_ROWS(mul_pkg::LVL1_ROWS)
    ) u_lvl1 (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .rows_in (lvl0_rows),
        .rows_out(lvl1_rows)
    );

    csa_level #(
        .IN_ROWS (mul_pkg::LVL1_ROWS),
        .OUT_ROWS(mul_pkg::LVL2_ROWS)
    ) u_lvl2 (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .rows_in (lvl1_rows),
        .rows_out(lvl2_rows)
    );

    csa_level #(
        .IN_ROWS (mul_pkg::LVL2_ROWS),
        .OUT_ROWS(mul_pkg::LVL3_ROWS)
    ) u_lvl3 (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .rows_in (lvl2_rows),
        .rows_out(lvl3_rows)
    );

    // row 0 is the sum row, row 1 the carry row
    final_cla_stage u_final (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .sum_row  (lvl3_rows[0]),
        .carry_row(lvl3_rows[1]),
        .product  (product)
    );

endmodule

`default_nettype wire

// File: bench/tb_booth_wallace_mul.sv
/* booth wallace multiplier testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_booth_wallace_mul;

    logic clk;
    logic reset;
    logic run;
    logic signed_mode;
    mul_pkg::operand_t multiplicand;
    mul_pkg::operand_t multiplier;
    mul_pkg::product_t product;

    // --------------------------------------------------
    // reference pipe that advances on run-high edges only
    // --------------------------------------------------
    mul_pkg::product_t model_pipe [mul_pkg::PIPE_DEPTH];
    logic [mul_pkg::PIPE_DEPTH-1:0] model_valid;

    // marks the driven operand pair as a real item
    logic item_valid;
    integer seed;
    int checked;

    booth_wallace_mul u_dut (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .signed_mode (signed_mode),
        .multiplicand(multiplicand),
        .multiplier  (multiplier),
        .product     (product)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    // exact product with both operands widened to 106 bits first
    function automatic mul_pkg::product_t exact_product(
        input logic sm,
        input mul_pkg::operand_t a,
        input mul_pkg::operand_t b
    );
        mul_pkg::product_t wa;
        mul_pkg::product_t wb;
        wa = {{mul_pkg::OPERAND_W{sm & a[mul_pkg::OPERAND_W-1]}}, a};
        wb = {{mul_pkg::OPERAND_W{sm & b[mul_pkg::OPERAND_W-1]}}, b};
        return wa * wb;
    endfunction

    function automatic mul_pkg::operand_t random_operand();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return mul_pkg::operand_t'({hi, lo});
    endfunction

    function automatic logic random_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    // zero, one, all ones, min, max, two alternating patterns
    function automatic mul_pkg::operand_t corner_value(input int idx);
        case (idx)
            0: return '0;
            1: return 53'h1;
            2: return '1;
            3: return 53'h10000000000000;
            4: return 53'h0FFFFFFFFFFFFF;
            5: return 53'h15555555555555;
            default: return 53'h0AAAAAAAAAAAAA;
        endcase
    endfunction

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_product(
        input string name,
        input mul_pkg::product_t expected,
        input mul_pkg::product_t actual
    );
        if (actual !== expected)
        begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            stop_on_failure("product differs from the reference model");
        end
    endtask

    // model update with the values the DUT sampled at this edge
    task automatic model_edge();
        if (reset)
        begin
            for (int k = 0; k < mul_pkg::PIPE_DEPTH; k++)
            begin
                model_pipe[k] = '0;
            end
            model_valid = '0;
        end
        else if (run)
        begin
            for (int k = mul_pkg::PIPE_DEPTH - 1; k > 0; k--)
            begin
                model_pipe[k] = model_pipe[k-1];
            end
            model_pipe[0] = exact_product(signed_mode, multiplicand, multiplier);
            model_valid = {model_valid[mul_pkg::PIPE_DEPTH-2:0], item_valid};
        end
    endtask

    task automatic step(input string name);
        @(posedge clk);
        model_edge();
        #1;
        check_product(name, model_pipe[mul_pkg::PIPE_DEPTH-1], product);
        if (model_valid[mul_pkg::PIPE_DEPTH-1] && run && !reset)
        begin
            checked++;
        end
    endtask

    task automatic apply(
        input string name,
        input logic r,
        input logic rn,
        input logic sm,
        input mul_pkg::operand_t a,
        input mul_pkg::operand_t b,
        input logic v
    );
        reset = r;
        run = rn;
        signed_mode = sm;
        multiplicand = a;
        multiplier = b;
        item_valid = v;
        step(name);
    endtask

    // run idle cycles until no real item is left in flight
    task automatic drain(input string name);
        int n;
        n = 0;
        while (|model_valid)
        begin
            if (n == 2 * mul_pkg::PIPE_DEPTH + 4)
            begin
                stop_on_failure("pipeline did not drain within the cycle limit");
            end
            else
            begin
                apply(name, 1'b0, 1'b1, 1'b0, '0, '0, 1'b0);
                n++;
            end
        end
    endtask

    task automatic wait_product_nonzero(input string name);
        int n;
        n = 0;
        while (product == '0)
        begin
            if (n == 2 * mul_pkg::PIPE_DEPTH)
            begin
                stop_on_failure("product stayed zero after new data entered the pipeline");
            end
            else
            begin
                apply(name, 1'b0, 1'b1, 1'b0, '0, '0, 1'b0);
                n++;
            end
        end
    endtask

    initial
    begin
        logic rn;
        seed = 49;
        checked = 0;
        reset = 1'b1;
        run = 1'b0;
        signed_mode = 1'b0;
        multiplicand = '0;
        multiplier = '0;
        item_valid = 1'b0;
        for (int k = 0; k < mul_pkg::PIPE_DEPTH; k++)
        begin
            model_pipe[k] = '0;
        end
        model_valid = '0;

        // reset and then idle edges with run low and live operands
        repeat (4) apply("reset", 1'b1, 1'b0, 1'b0, '0, '0, 1'b0);
        repeat (6)
        begin
            apply("idle after reset", 1'b0, 1'b0, 1'b0, random_operand(), random_operand(), 1'b0);
        end

        for (int n = 0; n < 300; n++)
        begin
            apply("unsigned", 1'b0, 1'b1, 1'b0, random_operand(), random_operand(), 1'b1);
        end
        drain("unsigned drain");

        for (int n = 0; n < 300; n++)
        begin
            apply("signed", 1'b0, 1'b1, 1'b1, random_operand(), random_operand(), 1'b1);
        end
        drain("signed drain");

        // every corner pair with the mode flipping on each cycle
        for (int i = 0; i < 7; i++)
        begin
            for (int j = 0; j < 7; j++)
            begin
                apply("corner", 1'b0, 1'b1, 1'b0, corner_value(i), corner_value(j), 1'b1);
                apply("corner", 1'b0, 1'b1, 1'b1, corner_value(i), corner_value(j), 1'b1);
            end
        end
        drain("corner drain");

        // run low on about one edge in four
        for (int n = 0; n < 400; n++)
        begin
            rn = (($random(seed) & 3) != 0);
            apply("stall", 1'b0, rn, random_bit(), random_operand(), random_operand(), 1'b1);
        end
        drain("stall drain");

        // reset with a full pipe and a live product at the output
        repeat (6) apply("mid fill", 1'b0, 1'b1, 1'b1, random_operand(), random_operand(), 1'b1);
        repeat (2) apply("mid reset", 1'b1, 1'b1, 1'b0, random_operand(), random_operand(), 1'b1);
        apply("refill", 1'b0, 1'b1, 1'b0, random_operand() | 53'h1, 53'h3, 1'b1);
        wait_product_nonzero("refill wait");
        for (int n = 0; n < 40; n++)
        begin
            apply("after reset", 1'b0, 1'b1, random_bit(), random_operand(), random_operand(), 1'b1);
        end
        drain("final drain");

        $display("%0d products checked", checked);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/mul_pkg.sv
rtl/booth_pp_gen.sv
rtl/csa_level.sv
rtl/final_cla_stage.sv
rtl/booth_wallace_mul.sv
bench/tb_booth_wallace_mul.sv

// File: Makefile
# Verilator build and run for the booth wallace multiplier

TOP ?= tb_booth_wallace_mul
FILELIST ?= vlog.f
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit status of the binary
run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "all tests passed" $(LOG); then \
		echo "no pass line found in $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
